// ==== Bender.yml ====
package:
  name: memory_upload

sources:
  - files:
      - hdl/msx_pkg.sv
      - hdl/upload_pkg.sv
      - hdl/upload_fsm.sv
      - hdl/fill_counter.sv
      - hdl/config_record.sv
      - hdl/memory_map.sv
      - hdl/memory_upload.sv
  - target: test
    files:
      - testbench/ddr3_model.sv
      - testbench/tb_memory_upload.sv

// ==== hdl/config_record.sv ====
`timescale 1ns/1ns

module config_record
   import upload_pkg::*;
   import msx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        rec_capture,
   input  logic [3:0]  rec_index,
   input  logic [7:0]  ddr3_dout,
   output logic        rec_valid,
   output config_typ_t rec_typ,
   output logic [3:0]  rec_slot,
   output data_id_t    rec_data_id,
   output page_size_t  rec_size,
   output device_t     rec_device,
   output mapper_t     rec_mapper,
   output logic [7:0]  rec_mode,
   output logic [7:0]  rec_param,
   output logic [3:0]  rec_expander,
   output msx_typ_t    rec_msx_typ
);

   logic [7:0] conf [record_len];
   logic       complete;

   always_ff @(posedge clk) begin
      if (rec_capture) begin
         conf[rec_index] <= ddr3_dout;
      end
   end

   // Fields are only trusted once all 16 bytes are in
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         complete <= 1'b0;
      end else if (rec_capture) begin
         complete <= rec_index == 4'(record_len - 1);
      end
   end

   assign rec_valid    = complete & ({conf[0], conf[1], conf[2]} == sig_msx);
   assign rec_typ      = config_typ_t'(conf[3][7:4]);
   assign rec_slot     = conf[3][3:0];   // Slot and subslot
   assign rec_data_id  = data_id_t'(conf[4]);
   assign rec_expander = conf[4][3:0];
   assign rec_msx_typ  = msx_typ_t'(conf[4][5:4]);
   assign rec_size     = page_size_t'({conf[5][2:0], conf[6]});
   assign rec_device   = device_t'(conf[7]);
   assign rec_mapper   = mapper_t'(conf[8]);
   assign rec_mode     = conf[9];
   assign rec_param    = conf[10];

endmodule

// ==== hdl/fill_counter.sv ====
`timescale 1ns/1ns

module fill_counter
   import upload_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        sdram_ready,
   input  logic        ddr3_ready,
   input  logic        fill_start,
   input  logic        fill_copy,
   input  logic [15:0] rec_size,
   output logic        fill_done,
   output ram_addr_t   ram_addr,
   output logic        ram_ce,
   output logic        fill_rd
);

   data_size_t count;
   logic       busy;
   logic       copy;
   logic       rd_pending;
   logic       ce_last;
   logic       last_byte;

   assign last_byte = count == data_size_t'(1);
   // Copy data is valid once the fetch has completed
   assign ram_ce    = busy & sdram_ready & ~ce_last & ddr3_ready & ~fill_rd & ~rd_pending;
   assign fill_done = ram_ce & last_byte;

   always_ff @(posedge clk) begin
      if (fill_start) begin
         count <= data_size_t'(rec_size) << page_shift;
      end else if (ram_ce) begin
         count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy       <= 1'b0;
         copy       <= 1'b0;
         rd_pending <= 1'b0;
         ce_last    <= 1'b0;
         fill_rd    <= 1'b0;
         ram_addr   <= '0;
      end else begin
         ce_last <= ram_ce;
         fill_rd <= 1'b0;
         if (fill_rd) begin
            rd_pending <= 1'b1;   // Follows ddr3_rd in the FSM
         end else if (ddr3_ready) begin
            rd_pending <= 1'b0;
         end
         if (fill_start) begin
            busy    <= 1'b1;
            copy    <= fill_copy;
            fill_rd <= fill_copy;   // Prefetch first byte
         end
         if (ram_ce) begin
            ram_addr <= ram_addr + 1'b1;
            if (last_byte) begin
               busy <= 1'b0;
            end else begin
               fill_rd <= copy;
            end
         end
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) ram_ce |-> sdram_ready ##1 !ram_ce)
      else $error("ram_ce not a single pulse under sdram_ready");

endmodule

// ==== hdl/memory_map.sv ====
`timescale 1ns/1ns

module memory_map
   import upload_pkg::*;
   import msx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        clean_en,
   input  block_idx_t  clean_idx,
   input  logic        store_en,
   input  logic        lookup_we,
   input  logic        cfg_we,
   input  ref_ram_t    ref_ram,
   input  logic        fill_copy,
   input  ram_addr_t   ram_addr,
   input  logic [7:0]  ddr3_dout,
   input  logic [3:0]  rec_slot,
   input  data_id_t    rec_data_id,
   input  page_size_t  rec_size,
   input  device_t     rec_device,
   input  mapper_t     rec_mapper,
   input  logic [7:0]  rec_mode,
   input  logic [7:0]  rec_param,
   input  logic [3:0]  rec_expander,
   input  msx_typ_t    rec_msx_typ,
   output logic [7:0]  ram_din,
   output mapper_t     slot_mapper  [slot_blocks],
   output device_t     slot_device  [slot_blocks],
   output ref_ram_t    slot_ref_ram [slot_blocks],
   output offset_t     slot_offset  [slot_blocks],
   output ram_addr_t   lookup_addr  [lookup_entries],
   output page_size_t  lookup_size  [lookup_entries],
   output logic        lookup_ro    [lookup_entries],
   output logic [3:0]  slot_expander_en,
   output msx_typ_t    msx_typ
);

   block_idx_t page_dst [4];
   block_idx_t page_src [4];

   assign ram_din = fill_copy ? ddr3_dout : ((ram_addr[8] == ram_addr[1]) ? 8'hFF : 8'h00);

   always_comb begin
      for (int p = 0; p < 4; p++) begin
         page_dst[p] = {rec_slot, 2'(p)};
         page_src[p] = {rec_slot, rec_param[2*p +: 2]};   // Mirror source page
      end
   end

   always_ff @(posedge clk) begin
      if (clean_en) begin
         slot_mapper[clean_idx] <= mapper_unused;
         slot_device[clean_idx] <= device_none;
      end
      if (store_en) begin
         for (int p = 0; p < 4; p++) begin
            case (rec_mode[2*p +: 2])
               2'd1: begin
                  slot_mapper[page_dst[p]]  <= slot_mapper[page_src[p]];
                  slot_device[page_dst[p]]  <= device_none;
                  slot_ref_ram[page_dst[p]] <= slot_ref_ram[page_src[p]];
                  slot_offset[page_dst[p]]  <= slot_offset[page_src[p]];
               end
               2'd2, 2'd3: begin
                  slot_mapper[page_dst[p]]  <= (rec_mode[2*p] == 1'b0) ? rec_mapper : mapper_unused;
                  slot_device[page_dst[p]]  <= rec_device;
                  slot_ref_ram[page_dst[p]] <= ref_ram;
                  slot_offset[page_dst[p]]  <= offset_t'(rec_param[2*p +: 2]);
               end
               default: ;   // Page untouched
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (lookup_we) begin
         lookup_addr[ref_ram] <= ram_addr;
         lookup_size[ref_ram] <= rec_size;
         lookup_ro[ref_ram]   <= rec_data_id != rom_ram;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         slot_expander_en <= '0;
         msx_typ          <= '0;
      end else if (cfg_we) begin
         slot_expander_en <= rec_expander;
         msx_typ          <= rec_msx_typ;
      end
   end

endmodule

// ==== hdl/memory_upload.sv ====
`timescale 1ns/1ns

module memory_upload
   import upload_pkg::*;
   import msx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic [26:0] ioctl_addr,
   output ddr_addr_t   ddr3_addr,
   output logic        ddr3_rd,
   output logic        ddr3_request,
   input  logic [7:0]  ddr3_dout,
   input  logic        ddr3_ready,
   output ram_addr_t   ram_addr,
   output logic [7:0]  ram_din,
   output logic        ram_ce,
   input  logic        sdram_ready,
   output logic        reset_rq,
   output mapper_t     slot_mapper  [slot_blocks],
   output device_t     slot_device  [slot_blocks],
   output ref_ram_t    slot_ref_ram [slot_blocks],
   output offset_t     slot_offset  [slot_blocks],
   output ram_addr_t   lookup_addr  [lookup_entries],
   output page_size_t  lookup_size  [lookup_entries],
   output logic        lookup_ro    [lookup_entries],
   output logic [3:0]  slot_expander_en,
   output msx_typ_t    msx_typ
);

   logic        rec_capture;
   logic [3:0]  rec_index;
   logic        clean_en;
   block_idx_t  clean_idx;
   logic        fill_start;
   logic        fill_copy;
   logic        fill_done;
   logic        fill_rd;
   logic        store_en;
   ref_ram_t    ref_ram;
   logic        lookup_we;
   logic        cfg_we;
   logic        rec_valid;
   config_typ_t rec_typ;
   logic [3:0]  rec_slot;
   data_id_t    rec_data_id;
   page_size_t  rec_size;
   device_t     rec_device;
   mapper_t     rec_mapper;
   logic [7:0]  rec_mode;
   logic [7:0]  rec_param;
   logic [3:0]  rec_expander;
   msx_typ_t    rec_msx_typ;

   upload_fsm u_fsm (
      .clk(clk), .rst_n(rst_n),
      .ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr),
      .ddr3_ready(ddr3_ready), .rec_valid(rec_valid), .rec_typ(rec_typ),
      .rec_data_id(rec_data_id), .rec_size(rec_size), .fill_done(fill_done), .fill_rd(fill_rd),
      .ddr3_addr(ddr3_addr), .ddr3_rd(ddr3_rd), .ddr3_request(ddr3_request),
      .reset_rq(reset_rq), .rec_capture(rec_capture), .rec_index(rec_index),
      .clean_en(clean_en), .clean_idx(clean_idx), .fill_start(fill_start),
      .fill_copy(fill_copy), .store_en(store_en), .ref_ram(ref_ram),
      .lookup_we(lookup_we), .cfg_we(cfg_we)
   );

   fill_counter u_fill (
      .clk(clk), .rst_n(rst_n), .sdram_ready(sdram_ready), .ddr3_ready(ddr3_ready),
      .fill_start(fill_start), .fill_copy(fill_copy), .rec_size(rec_size),
      .fill_done(fill_done), .ram_addr(ram_addr), .ram_ce(ram_ce), .fill_rd(fill_rd)
   );

   config_record u_record (
      .clk(clk), .rst_n(rst_n), .rec_capture(rec_capture), .rec_index(rec_index),
      .ddr3_dout(ddr3_dout), .rec_valid(rec_valid), .rec_typ(rec_typ), .rec_slot(rec_slot),
      .rec_data_id(rec_data_id), .rec_size(rec_size), .rec_device(rec_device),
      .rec_mapper(rec_mapper), .rec_mode(rec_mode), .rec_param(rec_param),
      .rec_expander(rec_expander), .rec_msx_typ(rec_msx_typ)
   );

   memory_map u_map (
      .clk(clk), .rst_n(rst_n), .clean_en(clean_en), .clean_idx(clean_idx),
      .store_en(store_en), .lookup_we(lookup_we), .cfg_we(cfg_we), .ref_ram(ref_ram),
      .fill_copy(fill_copy), .ram_addr(ram_addr), .ddr3_dout(ddr3_dout),
      .rec_slot(rec_slot), .rec_data_id(rec_data_id), .rec_size(rec_size),
      .rec_device(rec_device), .rec_mapper(rec_mapper), .rec_mode(rec_mode),
      .rec_param(rec_param), .rec_expander(rec_expander), .rec_msx_typ(rec_msx_typ),
      .ram_din(ram_din), .slot_mapper(slot_mapper), .slot_device(slot_device),
      .slot_ref_ram(slot_ref_ram), .slot_offset(slot_offset),
      .lookup_addr(lookup_addr), .lookup_size(lookup_size), .lookup_ro(lookup_ro),
      .slot_expander_en(slot_expander_en), .msx_typ(msx_typ)
   );

endmodule

// ==== hdl/msx_pkg.sv ====
package msx_pkg;

   // Slot, subslot and page give 64 blocks
   localparam int slot_blocks    = 64;
   localparam int lookup_entries = 16;

   typedef logic [7:0]  mapper_t;
   typedef logic [7:0]  device_t;
   typedef logic [7:0]  data_id_t;
   typedef logic [1:0]  msx_typ_t;
   typedef logic [3:0]  ref_ram_t;
   typedef logic [1:0]  offset_t;
   typedef logic [5:0]  block_idx_t;
   typedef logic [15:0] page_size_t;   // Count of 16 KB pages

   localparam mapper_t mapper_none   = 8'd0;
   localparam mapper_t mapper_ram    = 8'd1;
   localparam mapper_t mapper_unused = 8'hFF;

   localparam device_t device_none   = 8'd0;

   localparam data_id_t rom_none     = 8'd0;
   localparam data_id_t rom_rom      = 8'd1;
   localparam data_id_t rom_ram      = 8'd2;   // Checkerboard fill without DDR3 data

endpackage

// ==== hdl/upload_fsm.sv ====
`timescale 1ns/1ns

module upload_fsm
   import upload_pkg::*;
   import msx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic [26:0] ioctl_addr,
   input  logic        ddr3_ready,
   input  logic        rec_valid,
   input  config_typ_t rec_typ,
   input  data_id_t    rec_data_id,
   input  page_size_t  rec_size,
   input  logic        fill_done,
   input  logic        fill_rd,
   output ddr_addr_t   ddr3_addr,
   output logic        ddr3_rd,
   output logic        ddr3_request,
   output logic        reset_rq,
   output logic        rec_capture,
   output logic [3:0]  rec_index,
   output logic        clean_en,
   output block_idx_t  clean_idx,
   output logic        fill_start,
   output logic        fill_copy,
   output logic        store_en,
   output ref_ram_t    ref_ram,
   output logic        lookup_we,
   output logic        cfg_we
);

   state_t    state;
   ddr_addr_t image_size;
   logic      download_last;
   logic      cfg_done;
   logic      start;
   logic      step;
   logic      ref_add;

   assign cfg_done = download_last & ~ioctl_download & (ioctl_index[5:0] == 6'(config_index));
   assign start    = cfg_done & (state == idle);
   assign step     = ddr3_ready & ~ddr3_rd;   // No read in flight
   assign reset_rq = state != idle;

   assign clean_en    = step & (state == clean);
   assign rec_capture = step & (state == read_conf2);
   assign fill_start  = step & (state == fill_ram) & (rec_size != '0);
   assign lookup_we   = fill_start;   // Claim entry with start address
   assign store_en    = step & (state == store_slot);
   assign cfg_we      = step & (state == check_config) & rec_valid & (rec_typ == config_config);

   always_ff @(posedge clk) begin
      if (cfg_done) begin
         image_size <= ddr_addr_t'(ioctl_addr);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state         <= idle;
         download_last <= 1'b0;
         ddr3_addr     <= '0;
         ddr3_rd       <= 1'b0;
         ddr3_request  <= 1'b0;
         rec_index     <= '0;
         clean_idx     <= '0;
         ref_ram       <= '0;
         ref_add       <= 1'b0;
         fill_copy     <= 1'b0;
      end else begin
         download_last <= ioctl_download;
         if (ddr3_rd & ddr3_ready) begin
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 1'b1;
         end
         if (fill_rd) begin
            ddr3_rd <= 1'b1;   // Byte fetch for a copy fill
         end
         if (start) begin
            state        <= clean;
            ddr3_addr    <= '0;
            ddr3_request <= 1'b1;
            clean_idx    <= '0;
            ref_ram      <= '0;
            ref_add      <= 1'b0;
         end else if (step) begin
            case (state)
               idle: ddr3_request <= 1'b0;
               clean: begin
                  clean_idx <= clean_idx + 1'b1;
                  if (clean_idx == '1) begin
                     state <= read_conf;
                  end
               end
               read_conf: begin
                  rec_index <= '0;
                  if (ddr3_addr >= image_size) begin
                     state <= idle;   // End of image
                  end else begin
                     ddr3_rd <= 1'b1;
                     state   <= read_conf2;
                  end
               end
               read_conf2: begin
                  rec_index <= rec_index + 1'b1;
                  if (rec_index == 4'(record_len - 1)) begin
                     state <= check_config;
                  end else begin
                     ddr3_rd <= 1'b1;
                  end
               end
               check_config: begin
                  state <= idle;   // Missing signature stops the walk
                  if (rec_valid) begin
                     state <= read_conf;
                     case (rec_typ)
                        config_kbd_layout: ddr3_addr <= ddr3_addr + ddr_addr_t'(kbd_layout_len);
                        config_internal: begin
                           fill_copy <= rec_data_id != rom_ram;
                           state     <= (rec_data_id == rom_none) ? store_slot : fill_ram;
                        end
                        default: ;
                     endcase
                  end
               end
               fill_ram: begin
                  if (rec_size != '0) begin
                     ref_add <= 1'b1;
                     state   <= fill_ram2;
                  end else begin
                     state <= store_slot;
                  end
               end
               fill_ram2: begin
                  if (fill_done) begin
                     state <= store_slot;
                  end
               end
               store_slot: begin
                  ref_ram <= ref_ram + ref_ram_t'(ref_add);
                  ref_add <= 1'b0;
                  state   <= read_conf;
               end
               default: state <= idle;
            endcase
         end
      end
   end

   // A read, once issued, is held until the DDR3 side accepts it
   assert property (@(posedge clk) disable iff (!rst_n) $fell(ddr3_rd) |-> $past(ddr3_ready))
      else $error("ddr3_rd dropped without ddr3_ready");

endmodule

// ==== hdl/upload_pkg.sv ====
package upload_pkg;

   typedef enum logic [2:0] {
      idle,
      clean,
      read_conf,
      read_conf2,
      check_config,
      fill_ram,
      fill_ram2,
      store_slot
   } state_t;

   typedef logic [3:0]  config_typ_t;
   typedef logic [27:0] ddr_addr_t;
   typedef logic [26:0] ram_addr_t;
   typedef logic [24:0] data_size_t;

   // Record type codes from byte 3, upper nibble
   localparam config_typ_t config_internal   = 4'd4;
   localparam config_typ_t config_kbd_layout = 4'd7;
   localparam config_typ_t config_config     = 4'd8;

   localparam int record_len     = 16;
   localparam int kbd_layout_len = 512;
   localparam int page_shift     = 14;   // 16 KB pages
   localparam int config_index   = 1;

   localparam logic [23:0] sig_msx = 24'h4D5358;   // "MSX"

endpackage

// ==== project.f ====
hdl/msx_pkg.sv
hdl/upload_pkg.sv
hdl/upload_fsm.sv
hdl/fill_counter.sv
hdl/config_record.sv
hdl/memory_map.sv
hdl/memory_upload.sv
testbench/ddr3_model.sv
testbench/tb_memory_upload.sv

// ==== testbench/ddr3_model.sv ====
`timescale 1ns/1ns

module ddr3_model
   import upload_pkg::*;
#(
   parameter int addr_bits = 15,
   parameter int seed_init = 70
) (
   input  logic       clk,
   input  ddr_addr_t  ddr3_addr,
   input  logic       ddr3_rd,
   output logic [7:0] ddr3_dout,
   output logic       ddr3_ready
);

   logic [7:0] mem [2**addr_bits];   // Image written by the testbench
   integer     seed;
   logic       take;
   ddr_addr_t  addr;

   initial begin
      seed       = seed_init;
      ddr3_dout  = 8'h00;
      ddr3_ready = 1'b0;
      for (int i = 0; i < 2**addr_bits; i++) begin
         mem[i] = 8'(i) ^ 8'(i >> 8);
      end
   end

   // A read completes in a cycle with ddr3_rd and ddr3_ready both high
   always begin
      @(negedge clk);
      take = ddr3_rd & ddr3_ready;
      addr = ddr3_addr;
      @(posedge clk);
      #1;
      if (take) begin
         ddr3_dout = mem[addr[addr_bits-1:0]];   // Held until the next read
      end
      ddr3_ready = ($random(seed) & 3) != 0;   // Stall about one cycle in four
   end

endmodule

// ==== testbench/tb_memory_upload.sv ====
`timescale 1ns/1ns

module tb_memory_upload
   import upload_pkg::*;
   import msx_pkg::*;
();

   localparam int rows     = 5;
   localparam int max_recs = 4;
   localparam int ram_bits = 17;

   logic        clk;
   logic        rst_n;
   logic        ioctl_download;
   logic [15:0] ioctl_index;
   logic [26:0] ioctl_addr;
   ddr_addr_t   ddr3_addr;
   logic        ddr3_rd;
   logic        ddr3_request;
   logic [7:0]  ddr3_dout;
   logic        ddr3_ready;
   ram_addr_t   ram_addr;
   logic [7:0]  ram_din;
   logic        ram_ce;
   logic        sdram_ready;
   logic        reset_rq;
   mapper_t     slot_mapper  [slot_blocks];
   device_t     slot_device  [slot_blocks];
   ref_ram_t    slot_ref_ram [slot_blocks];
   offset_t     slot_offset  [slot_blocks];
   ram_addr_t   lookup_addr  [lookup_entries];
   page_size_t  lookup_size  [lookup_entries];
   logic        lookup_ro    [lookup_entries];
   logic [3:0]  slot_expander_en;
   msx_typ_t    msx_typ;

   // One row per scenario with record bytes 0 to 10 and byte 0 on top
   logic [87:0] recs     [rows][max_recs];
   int          n_recs   [rows];
   logic [3:0]  exp_slot [rows];
   logic [21:0] exp_page [rows][4];   // Mapper, device, ref, offset
   logic [5:0]  exp_bios [rows];      // Expander mask, machine type

   int          image_len;
   int          walk_end;
   int          fill_bytes;
   int          n_lookup;
   ram_addr_t   ram_ptr;   // Fill address carried across uploads
   ram_addr_t   row_start;
   ram_addr_t   lk_addr [lookup_entries];
   page_size_t  lk_size [lookup_entries];
   logic        lk_ro   [lookup_entries];
   logic [7:0]  exp_ram [2**ram_bits];
   logic [7:0]  cap_ram [2**ram_bits];
   int          cap_count;
   logic        rd_wait;
   int          cycles;
   int          limit;
   integer      seed;
   integer      stall_seed;

   memory_upload dut (
      .clk(clk), .rst_n(rst_n), .ioctl_download(ioctl_download),
      .ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr), .ddr3_addr(ddr3_addr),
      .ddr3_rd(ddr3_rd), .ddr3_request(ddr3_request), .ddr3_dout(ddr3_dout),
      .ddr3_ready(ddr3_ready), .ram_addr(ram_addr), .ram_din(ram_din), .ram_ce(ram_ce),
      .sdram_ready(sdram_ready), .reset_rq(reset_rq), .slot_mapper(slot_mapper),
      .slot_device(slot_device), .slot_ref_ram(slot_ref_ram), .slot_offset(slot_offset),
      .lookup_addr(lookup_addr), .lookup_size(lookup_size), .lookup_ro(lookup_ro),
      .slot_expander_en(slot_expander_en), .msx_typ(msx_typ)
   );

   ddr3_model #(.seed_init(70)) ddr (
      .clk(clk), .ddr3_addr(ddr3_addr), .ddr3_rd(ddr3_rd),
      .ddr3_dout(ddr3_dout), .ddr3_ready(ddr3_ready)
   );

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [87:0] make_rec(input logic [23:0] sig, input config_typ_t typ,
         input logic [3:0] slot, input logic [7:0] b4, input logic [10:0] size,
         input logic [7:0] dev, input logic [7:0] mapper, input logic [7:0] mode,
         input logic [7:0] param);
      return {sig, typ, slot, b4, 5'b00000, size, dev, mapper, mode, param};
   endfunction

   function automatic logic [21:0] page_entry(input mapper_t m, input device_t d,
         input ref_ram_t r, input offset_t o);
      return {m, d, r, o};
   endfunction

   // Bytes written to RAM for one record
   function automatic int fill_len(input logic [87:0] rec);
      page_size_t size;
      size = page_size_t'({rec[42:40], rec[39:32]});
      if (rec[63:60] == config_internal && rec[55:48] != rom_none) begin
         return int'(size) << page_shift;
      end
      return 0;
   endfunction

   // Bytes that follow a record in DDR3
   function automatic int payload_len(input logic [87:0] rec);
      if (rec[63:60] == config_kbd_layout) begin
         return kbd_layout_len;
      end
      if (rec[63:60] == config_internal && rec[55:48] != rom_ram) begin
         return fill_len(rec);
      end
      return 0;
   endfunction

   function automatic logic [7:0] checker_byte(input ram_addr_t a);
      return (a[8] == a[1]) ? 8'hFF : 8'h00;
   endfunction

   function automatic int run_limit();
      int total;
      total = 0;
      for (int r = 0; r < rows; r++) begin
         total += 64;
         for (int k = 0; k < n_recs[r]; k++) begin
            total += record_len + payload_len(recs[r][k]) + fill_len(recs[r][k]);
         end
      end
      return 4 * record_len * total;
   endfunction

   task automatic load_table();
      for (int r = 0; r < rows; r++) begin
         exp_slot[r] = '0;
         for (int p = 0; p < 4; p++) begin
            exp_page[r][p] = page_entry(mapper_unused, device_none, '0, '0);
         end
      end
      // Configuration record only
      n_recs[0]      = 1;
      recs[0][0]     = make_rec(sig_msx, config_config, 4'h0, 8'h1A, 0, 0, 0, 0, 0);
      exp_bios[0]    = {4'hA, 2'd1};
      // ROM copy of one page into slot 0, subslot 3
      n_recs[1]      = 1;
      recs[1][0]     = make_rec(sig_msx, config_internal, 4'h3, rom_rom, 1, 8'h05,
                                mapper_none, 8'h08, 8'h00);
      exp_slot[1]    = 4'h3;
      exp_page[1][1] = page_entry(mapper_none, 8'h05, 4'd0, 2'd0);
      exp_bios[1]    = {4'hA, 2'd1};
      // Checkerboard fill
      n_recs[2]      = 1;
      recs[2][0]     = make_rec(sig_msx, config_internal, 4'h8, rom_ram, 1, device_none,
                                mapper_ram, 8'hA0, 8'h40);
      exp_slot[2]    = 4'h8;
      exp_page[2][2] = page_entry(mapper_ram, device_none, 4'd0, 2'd0);
      exp_page[2][3] = page_entry(mapper_ram, device_none, 4'd0, 2'd1);
      exp_bios[2]    = {4'hA, 2'd1};
      // Modes 2 and 3, then modes 2 and 1 on the same slot
      n_recs[3]      = 2;
      recs[3][0]     = make_rec(sig_msx, config_internal, 4'hC, rom_ram, 1, 8'h21, 8'h11,
                                8'h0E, 8'h04);
      recs[3][1]     = make_rec(sig_msx, config_internal, 4'hC, rom_ram, 1, 8'h42, 8'h33,
                                8'h60, 8'h20);
      exp_slot[3]    = 4'hC;
      exp_page[3][0] = page_entry(8'h11, 8'h21, 4'd0, 2'd0);
      exp_page[3][1] = page_entry(mapper_unused, 8'h21, 4'd0, 2'd1);
      exp_page[3][2] = page_entry(8'h33, 8'h42, 4'd1, 2'd2);
      exp_page[3][3] = page_entry(8'h11, device_none, 4'd0, 2'd0);   // Copy of page 0
      exp_bios[3]    = {4'hA, 2'd1};
      // Keyboard layout, config, bad signature, config that must be ignored
      n_recs[4]      = 4;
      recs[4][0]     = make_rec(sig_msx, config_kbd_layout, 4'h0, 8'h00, 0, 0, 0, 0, 0);
      recs[4][1]     = make_rec(sig_msx, config_config, 4'h0, 8'h25, 0, 0, 0, 0, 0);
      recs[4][2]     = make_rec(24'h4D5359, config_config, 4'h0, 8'h3F, 0, 0, 0, 0, 0);
      recs[4][3]     = make_rec(sig_msx, config_config, 4'h0, 8'h3F, 0, 0, 0, 0, 0);
      exp_bios[4]    = {4'h5, 2'd2};
   endtask

   task automatic build_image(input int row);
      logic [87:0] rec;
      int          pos;
      logic        alive;
      pos        = 0;
      alive      = 1'b1;
      fill_bytes = 0;
      n_lookup   = 0;
      row_start  = ram_ptr;
      for (int r = 0; r < n_recs[row]; r++) begin
         rec = recs[row][r];
         for (int b = 0; b < record_len; b++) begin
            ddr.mem[pos + b] = (b < 11) ? rec[87 - 8*b -: 8] : 8'h00;
         end
         pos += record_len;
         if (alive) begin
            walk_end = pos;
         end
         alive = alive && (rec[87:64] == sig_msx);
         for (int i = 0; i < payload_len(rec); i++) begin
            ddr.mem[pos + i] = 8'($random(seed));
         end
         if (alive && fill_len(rec) != 0) begin
            lk_addr[n_lookup] = ram_ptr;
            lk_size[n_lookup] = page_size_t'({rec[42:40], rec[39:32]});
            lk_ro[n_lookup]   = rec[55:48] != rom_ram;
            n_lookup++;
            for (int i = 0; i < fill_len(rec); i++) begin
               exp_ram[ram_ptr[ram_bits-1:0]] = (payload_len(rec) != 0) ? ddr.mem[pos + i]
                                                                       : checker_byte(ram_ptr);
               ram_ptr++;
            end
            fill_bytes += fill_len(rec);
         end
         if (alive) begin
            walk_end = pos + payload_len(rec);
         end
         pos += payload_len(rec);
      end
      image_len = pos;
   endtask

   task automatic start_upload(input int len);
      @(posedge clk);
      #1;
      ioctl_index    = 16'(config_index);
      ioctl_addr     = 27'(len);
      ioctl_download = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      ioctl_download = 1'b0;
      @(posedge clk);
      @(negedge clk);
      check("reset_rq", reset_rq, 1'b1);   // One cycle after the falling edge
      check("ddr3_request", ddr3_request, 1'b1);
      while (reset_rq) begin
         @(negedge clk);
      end
      while (ddr3_request) begin
         @(negedge clk);
      end
   endtask

   task automatic check_row(input int row);
      logic [21:0] e;
      ram_addr_t   a;
      for (int b = 0; b < slot_blocks; b++) begin
         e = (b / 4 == exp_slot[row]) ? exp_page[row][b % 4]
                                      : page_entry(mapper_unused, device_none, '0, '0);
         check($sformatf("slot_mapper[%0d]", b), slot_mapper[b], e[21:14]);
         check($sformatf("slot_device[%0d]", b), slot_device[b], e[13:6]);
         if (e[21:14] != mapper_unused || e[13:6] != device_none) begin
            check($sformatf("slot_ref_ram[%0d]", b), slot_ref_ram[b], e[5:2]);
            check($sformatf("slot_offset[%0d]", b), slot_offset[b], e[1:0]);
         end
      end
      for (int k = 0; k < n_lookup; k++) begin
         check($sformatf("lookup_addr[%0d]", k), lookup_addr[k], lk_addr[k]);
         check($sformatf("lookup_size[%0d]", k), lookup_size[k], lk_size[k]);
         check($sformatf("lookup_ro[%0d]", k), lookup_ro[k], lk_ro[k]);
      end
      check("slot_expander_en", slot_expander_en, exp_bios[row][5:2]);
      check("msx_typ", msx_typ, exp_bios[row][1:0]);
      check("ddr3_addr", ddr3_addr, walk_end);
      check("ram_ce count", cap_count, fill_bytes);
      for (int i = 0; i < fill_bytes; i++) begin
         a = row_start + ram_addr_t'(i);
         check($sformatf("ram_din at %0h", a), cap_ram[a[ram_bits-1:0]],
               exp_ram[a[ram_bits-1:0]]);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Stall bits taken apart from the DDR3 model's draw
   always begin
      @(posedge clk);
      #1;
      sdram_ready = (($random(stall_seed) >> 8) & 3) != 0;
   end

   // RAM capture and handshake checks where outputs are settled
   always @(negedge clk) begin
      if (rst_n) begin
         if (ram_ce) begin
            check("sdram_ready", sdram_ready, 1'b1);
            cap_ram[ram_addr[ram_bits-1:0]] = ram_din;
            cap_count++;
         end
         if (rd_wait) begin
            check("ddr3_rd", ddr3_rd, 1'b1);   // Must hold until ddr3_ready
         end
         rd_wait = ddr3_rd & ~ddr3_ready;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("The upload never finished within %0d cycles", limit);
         $display("Simulation failed");
         $fatal(1, "timeout");
      end
   end

   initial begin
      seed           = 70;
      stall_seed     = 70;
      rst_n          = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index    = '0;
      ioctl_addr     = '0;
      sdram_ready    = 1'b0;
      rd_wait        = 1'b0;
      cycles         = 0;
      cap_count      = 0;
      ram_ptr        = '0;
      load_table();
      limit = run_limit();
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      check("reset_rq", reset_rq, 1'b0);
      check("ddr3_rd", ddr3_rd, 1'b0);
      check("ddr3_request", ddr3_request, 1'b0);
      check("ram_ce", ram_ce, 1'b0);
      for (int row = 0; row < rows; row++) begin
         build_image(row);
         cap_count = 0;
         start_upload(image_len);
         check_row(row);
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule
